//--- project.f
+incdir+testbench
src/fixed_point_pkg.sv
src/expmul_pkg.sv
src/expmul_lane.sv
src/lane_dispatch.sv
src/result_collect.sv
src/expmul_array.sv
testbench/expmul_tb.sv

//--- testbench/expmul_ref.svh
/* Reference model of the exp(a - b) shift approximation
   plus compare tasks for whole results and shift amounts */
`ifndef EXPMUL_REF_SVH
`define EXPMUL_REF_SVH

// Expected result worked out in plain integers
function automatic expmul_res_t expmul_ref(input expmul_req_t req, input int vec_len);
    int          d;      // a - b in 1/16 steps
    int          dq;     // Truncated to 1/4 steps
    int          l;      // log2(e)*d estimate in 1/4 steps
    int          shift;
    elem_t       e;
    expmul_res_t r;

    d     = int'(req.a_val) - int'(req.b_val);
    dq    = d >>> 2;                         // Floor of d/4
    l     = dq + (dq >>> 1) - (dq >>> 4);
    shift = -(l >>> 2);                      // Minus floor of L

    if (req.opcode == OP_BYPASS || d > 0 || shift < 0) begin
        shift = 0;                           // Scale of 1 or above needs no shift
    end else if (shift > MAX_SHIFT) begin
        shift = MAX_SHIFT;
    end

    r       = '0;
    r.tag   = req.tag;
    r.shamt = shamt_t'(shift);
    for (int i = 0; i < VEC_LEN_MAX; i++) begin
        e = req.vec[i];
        if (i < vec_len) begin
            r.vec[i] = e >>> shift;          // Arithmetic shift keeps the sign
        end else begin
            r.vec[i] = '0;                   // Unused slots come back zero
        end
    end
    return r;
endfunction

// Whole result including tag, so order slips show up here
task automatic check_res(input string name, input expmul_res_t exp_res,
                         input expmul_res_t act_res);
    if (act_res !== exp_res) begin
        $display({"** Error [%s] result: expected tag=%0d shamt=%0d vec=%h,",
                  " actual tag=%0d shamt=%0d vec=%h"},
                 name, exp_res.tag, exp_res.shamt, exp_res.vec,
                 act_res.tag, act_res.shamt, act_res.vec);
        fail_run();
    end
endtask

task automatic check_shamt(input string name, input shamt_t exp_sh, input shamt_t act_sh);
    if (act_sh !== exp_sh) begin
        $display("** Error [%s] shift amount: expected %0d, actual %0d",
                 name, exp_sh, act_sh);
        fail_run();
    end
endtask

`endif

//--- testbench/expmul_tb.sv
/* Testbench for the multi-lane rescale engine
   Directed and random requests, scoreboard checker, timeout */
module expmul_tb
    import fixed_point_pkg::*;
    import expmul_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int VEC_LEN     = 4;   // DUT default
    localparam int NUM_DIRECT  = 21;  // Directed requests over tests 1 to 3
    localparam int NUM_RANDOM  = 300;
    localparam int TOTAL_REQ   = NUM_DIRECT + 2 * NUM_RANDOM;
    localparam int MAX_CYCLES  = 20 * TOTAL_REQ + 200;

    logic        clk, rst;
    logic        in_valid, in_ready;
    expmul_req_t in_req;
    logic        out_valid, out_ready;
    expmul_res_t out_res;

    integer      seed;
    int          cycles = 0;
    string       test_name;
    logic [7:0]  next_tag;
    logic        stim_done;
    logic        held = 1'b0;     // Result offered but not taken last edge
    expmul_res_t held_res;
    expmul_res_t exp_q [$];       // Scoreboard
    string       name_q [$];
    expmul_req_t rand_reqs [NUM_RANDOM];

    // Directed score pairs
    int neg_a [11] = '{0, 0, 0, 0, 0, -16, 0, -32, -64, -100, -128};
    int neg_b [11] = '{1, 4, 8, 16, 24, 16, 48, 32, 40, 27, 127};
    int byp_a [4]  = '{-100, 127, 0, -5};
    int byp_b [4]  = '{100, -128, 0, 60};
    int pos_a [3]  = '{20, 127, 1};
    int pos_b [3]  = '{10, -128, 0};

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    `include "expmul_ref.svh"

    expmul_array expmul_array_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_res   (out_res),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    function automatic expmul_req_t make_req(input opcode_e op, input int a, input int b,
                                             input vec_t v);
        expmul_req_t r;
        r        = '0;
        r.opcode = op;
        r.a_val  = score_t'(a);
        r.b_val  = score_t'(b);
        r.vec    = v;
        return r;
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        v = '0;
        for (int i = 0; i < VEC_LEN; i++) v[i] = elem_t'($random(seed));
        return v;
    endfunction

    // Sign extremes and a plain positive value
    function automatic vec_t neg_vec();
        vec_t v;
        v    = '0;
        v[0] = -26'sd1;
        v[1] = 26'sh2000000;    // Most negative element
        v[2] = -26'sd100000;
        v[3] = 26'sd1048576;
        return v;
    endfunction

    function automatic expmul_req_t rand_req();
        opcode_e op;
        op = (($random(seed) & 7) == 0) ? OP_BYPASS : OP_RESCALE;  // Bypass now and then
        return make_req(op, $random(seed), $random(seed), rand_vec());
    endfunction

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input expmul_req_t req);
        expmul_req_t r;
        r        = req;
        r.tag    = next_tag;
        next_tag = next_tag + 1'b1;
        in_req   = r;
        in_valid = 1'b1;
        while (in_ready !== 1'b1) @(negedge clk);  // in_ready steady between rising edges
        exp_q.push_back(expmul_ref(r, VEC_LEN));
        name_q.push_back(test_name);
        @(negedge clk);
    endtask

    task automatic wait_drain();
        in_valid = 1'b0;
        in_req   = '0;
        while (exp_q.size() != 0) @(negedge clk);  // Timeout guards this
    endtask

    initial begin
        seed      = 32'he05d5e11;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        next_tag  = '0;
        stim_done = 1'b0;
        test_name = "reset";
        repeat (2) @(negedge clk);
        rst = 1'b0;
        if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
            $display("After reset in_ready is not high or out_valid is not low");
            fail_run();
        end

        test_name = "equal_scores";
        send_req(make_req(OP_RESCALE, 0, 0, rand_vec()));
        send_req(make_req(OP_RESCALE, 16, 16, neg_vec()));
        send_req(make_req(OP_RESCALE, -40, -40, rand_vec()));
        wait_drain();

        test_name = "neg_diff";
        for (int i = 0; i < 11; i++) begin
            send_req(make_req(OP_RESCALE, neg_a[i], neg_b[i], (i % 2) ? rand_vec() : neg_vec()));
        end
        wait_drain();

        test_name = "bypass";
        for (int i = 0; i < 4; i++) send_req(make_req(OP_BYPASS, byp_a[i], byp_b[i], neg_vec()));
        test_name = "pos_diff";
        for (int i = 0; i < 3; i++) send_req(make_req(OP_RESCALE, pos_a[i], pos_b[i], rand_vec()));
        wait_drain();

        test_name = "random_stream";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_reqs[i] = rand_req();
            send_req(rand_reqs[i]);
        end
        wait_drain();

        // Replay the same stream against a stalling output
        test_name = "random_backpressure";
        fork
            begin
                for (int i = 0; i < NUM_RANDOM; i++) send_req(rand_reqs[i]);
                in_valid  = 1'b0;
                stim_done = 1'b1;
            end
            begin
                out_ready = 1'b0;
                repeat (40) @(negedge clk);  // Long stall, every buffer fills
                if (in_ready !== 1'b0) begin
                    $display("in_ready stayed high while the output was stalled");
                    fail_run();
                end
                while (!stim_done) begin
                    out_ready = (($random(seed) & 3) != 0);
                    @(negedge clk);
                end
                out_ready = 1'b1;
            end
        join
        wait_drain();

        test_name = "idle_check";
        out_ready = 1'b1;
        repeat (10) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
                $display("Idle engine shows out_valid high or in_ready low, credits missing");
                fail_run();
            end
        end

        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            fail_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    // Scoreboard compare on every taken result
    always @(posedge clk) begin
        expmul_res_t exp_res;
        string       nm;
        if (!rst) begin
            if (held) begin
                if (out_valid !== 1'b1) begin
                    $display("out_valid dropped before the result was taken");
                    fail_run();
                end
                check_res("output_hold", held_res, out_res);  // Must stay steady
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out with no request waiting for it");
                    fail_run();
                end else begin
                    exp_res = exp_q.pop_front();
                    nm      = name_q.pop_front();
                    check_shamt(nm, exp_res.shamt, out_res.shamt);
                    check_res(nm, exp_res, out_res);
                end
            end
            held     = out_valid && !out_ready;
            held_res = out_res;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

endmodule

//--- src/expmul_array.sv
/* Multi-lane rescale engine top: dispatcher,
   generated lanes and in-order collector */
module expmul_array
    import expmul_pkg::*;
#(
    parameter int NUM_LANES = 4,  // 1 to 8
    parameter int BUF_DEPTH = 4,  // Result slots per lane, 2 or more
    parameter int VEC_LEN   = 4   // Live elements per vector
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  expmul_req_t in_req,
    output logic        in_ready,
    output logic        out_valid,
    output expmul_res_t out_res,
    input  logic        out_ready
);

    logic [NUM_LANES-1:0] lane_valid;            // One-hot issue strobe
    expmul_req_t          lane_req;              // Shared request bus
    logic [NUM_LANES-1:0] res_valid;
    expmul_res_t          res [NUM_LANES];
    logic [NUM_LANES-1:0] credit_ret;            // Collector to dispatcher

    lane_dispatch #(
        .NUM_LANES(NUM_LANES),
        .BUF_DEPTH(BUF_DEPTH)
    ) dispatch_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_ready   (in_ready),
        .lane_valid (lane_valid),
        .lane_req   (lane_req),
        .credit_ret (credit_ret)
    );

    // Identical two-stage lanes
    for (genvar i = 0; i < NUM_LANES; i++) begin : lane_gen
        expmul_lane #(
            .VEC_LEN(VEC_LEN)
        ) lane_inst (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (lane_valid[i]),
            .in_req    (lane_req),
            .out_valid (res_valid[i]),
            .out_res   (res[i])
        );
    end

    result_collect #(
        .NUM_LANES(NUM_LANES),
        .BUF_DEPTH(BUF_DEPTH)
    ) collect_inst (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res        (res),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_ready  (out_ready),
        .credit_ret (credit_ret)
    );

endmodule

//--- src/result_collect.sv
/* Per-lane result FIFOs, in-order round-robin drain
   to the output and credit return to the dispatcher */
module result_collect
    import expmul_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int BUF_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_LANES-1:0] res_valid,
    input  expmul_res_t          res [NUM_LANES],
    output logic                 out_valid,
    output expmul_res_t          out_res,
    input  logic                 out_ready,
    output logic [NUM_LANES-1:0] credit_ret
);

    localparam int DRN_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int IDX_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    typedef enum logic {
        COLLECT_WAIT,     // Pointed FIFO empty
        COLLECT_PRESENT   // Head of pointed FIFO on the output
    } collect_state_e;

    collect_state_e   state, state_nxt;
    expmul_res_t      mem [NUM_LANES][BUF_DEPTH];
    logic [IDX_W-1:0] wr_ptr [NUM_LANES];
    logic [IDX_W-1:0] rd_ptr [NUM_LANES];
    logic [CNT_W-1:0] cnt [NUM_LANES];
    logic [CNT_W-1:0] cnt_nxt [NUM_LANES];
    logic [DRN_W-1:0] drain, drain_nxt;  // Lane being drained
    logic             take;

    // Circular index step
    function automatic logic [IDX_W-1:0] idx_inc(input logic [IDX_W-1:0] p);
        return (p == IDX_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign out_valid = (state == COLLECT_PRESENT);
    assign out_res   = mem[drain][rd_ptr[drain]];  // Head stays put until taken
    assign take      = out_valid && out_ready;

    always_comb begin
        credit_ret        = '0;
        credit_ret[drain] = take;  // One pulse per drained result
    end

    // Same rotation as the dispatcher keeps arrival order
    assign drain_nxt = !take ? drain :
                       (drain == DRN_W'(NUM_LANES - 1)) ? '0 : drain + 1'b1;

    for (genvar i = 0; i < NUM_LANES; i++) begin : cnt_gen
        assign cnt_nxt[i] = cnt[i] + CNT_W'(res_valid[i]) - CNT_W'(credit_ret[i]);

        // Credits keep every FIFO below full
        no_full_wr_a: assert property (@(posedge clk) disable iff (rst)
            res_valid[i] |-> cnt[i] < CNT_W'(BUF_DEPTH))
            else $error("write into full buffer on lane %0d", i);
    end

    always_comb begin
        state_nxt = state;
        case (state)
            COLLECT_WAIT: begin
                if (cnt_nxt[drain] != '0) state_nxt = COLLECT_PRESENT;  // Write just landed
            end
            COLLECT_PRESENT: begin
                if (take && cnt_nxt[drain_nxt] == '0) state_nxt = COLLECT_WAIT;
            end
            default: state_nxt = COLLECT_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= COLLECT_WAIT;
            drain <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                cnt[i]    <= '0;
            end
        end else begin
            state <= state_nxt;
            drain <= drain_nxt;
            for (int i = 0; i < NUM_LANES; i++) begin
                cnt[i] <= cnt_nxt[i];
                if (res_valid[i])  wr_ptr[i] <= idx_inc(wr_ptr[i]);
                if (credit_ret[i]) rd_ptr[i] <= idx_inc(rd_ptr[i]);  // Pop head
            end
        end
    end

    // Buffer storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (res_valid[i]) mem[i][wr_ptr[i]] <= res[i];
        end
    end

endmodule

//--- src/lane_dispatch.sv
/* Round-robin request dispatcher with one credit counter per lane */
module lane_dispatch
    import expmul_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int BUF_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  expmul_req_t          in_req,
    output logic                 in_ready,
    output logic [NUM_LANES-1:0] lane_valid,
    output expmul_req_t          lane_req,
    input  logic [NUM_LANES-1:0] credit_ret
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [PTR_W-1:0] rr_ptr;              // Lane that gets the next request
    logic [CNT_W-1:0] credit [NUM_LANES];  // Free buffer slots per lane
    logic             accept;

    // Strict order, wait on the pointed lane even if others have room
    assign in_ready = (credit[rr_ptr] != '0);
    assign accept   = in_valid && in_ready;
    assign lane_req = in_req;  // Shared by all lanes, lane_valid picks one

    always_comb begin
        lane_valid         = '0;
        lane_valid[rr_ptr] = accept;  // Issue same cycle as accept
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (accept) begin
            // Wrap explicitly, lane count need not be a power of two
            rr_ptr <= (rr_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : rr_ptr + 1'b1;
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : credit_gen
        always_ff @(posedge clk) begin
            if (rst) begin
                credit[i] <= CNT_W'(BUF_DEPTH);  // Every buffer starts empty
            end else begin
                // Issue and return may land together
                credit[i] <= credit[i] - CNT_W'(lane_valid[i])
                                       + CNT_W'(credit_ret[i]);
            end
        end

        // Collector returns only what was issued
        credit_ovf_a: assert property (@(posedge clk) disable iff (rst)
            (credit_ret[i] && !lane_valid[i]) |-> credit[i] < CNT_W'(BUF_DEPTH))
            else $error("credit overflow on lane %0d", i);
    end

endmodule

//--- src/expmul_lane.sv
/* Two-stage rescale lane: exponent approximation in stage 1,
   arithmetic barrel shift of the vector after stage 2 */
module expmul_lane
    import fixed_point_pkg::*;
    import expmul_pkg::*;
#(
    parameter int VEC_LEN = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  expmul_req_t in_req,
    output logic        out_valid,
    output expmul_res_t out_res
);

    localparam int SH_STEPS = 5;  // Steps of 16, 8, 4, 2, 1

    // Stage 1
    logic        s1_valid;
    expmul_req_t s1_req;
    diff_t       d;           // a - b, Q5.4
    diff_q2_t    d_q2;        // Q5.2
    log_t        d_ext;       // d_q2 widened to Q6.2
    log_t        l_q;         // L in Q6.2
    logic signed [5:0] l_int; // floor(L)
    logic signed [6:0] neg_l; // -floor(L), room for +23
    shamt_t      shamt_nxt;

    // Stage 2
    logic                s2_valid;
    expmul_res_t         s2_res;   // Vector still unshifted here
    logic [SH_STEPS-1:0] sh_amt;
    elem_t               shifted [VEC_LEN_MAX];

    // Lane never stalls, valid just walks down the pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) s1_req <= in_req;  // Capture request
    end

    // Exponent approximation, exp(d) = 2^(log2(e)*d)
    always_comb begin
        d     = diff_t'(s1_req.a_val) - diff_t'(s1_req.b_val);
        d_q2  = d[$bits(diff_t)-1:2];    // Truncate, rounds toward -inf
        d_ext = d_q2;                    // Sign extend
        l_q   = d_ext + (d_ext >>> 1) - (d_ext >>> 4);  // ~1.4375*d
        l_int = l_q[$bits(log_t)-1:2];   // Integer part, floored
        neg_l = 7'sd0 - l_int;

        // Only a scale below 1 turns into a shift
        if (s1_req.opcode == OP_BYPASS || d > 0 || neg_l <= 0) begin
            shamt_nxt = '0;
        end else if (neg_l > MAX_SHIFT) begin
            shamt_nxt = shamt_t'(MAX_SHIFT);  // Saturate tiny scales
        end else begin
            shamt_nxt = shamt_t'(neg_l);
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_res.tag   <= s1_req.tag;
            s2_res.shamt <= shamt_nxt;
            s2_res.vec   <= s1_req.vec;
        end
    end

    assign sh_amt = SH_STEPS'(s2_res.shamt);  // Top step idle while MAX_SHIFT is 15

    // Barrel shifter per element, largest step first
    for (genvar i = 0; i < VEC_LEN_MAX; i++) begin : elem_gen
        if (i < VEC_LEN) begin : live_gen
            elem_t step [SH_STEPS+1];

            assign step[0] = s2_res.vec[i];
            for (genvar k = 0; k < SH_STEPS; k++) begin : step_gen
                assign step[k+1] = sh_amt[SH_STEPS-1-k] ?
                                   (step[k] >>> (1 << (SH_STEPS-1-k))) : step[k];
            end
            assign shifted[i] = step[SH_STEPS];
        end else begin : pad_gen
            assign shifted[i] = '0;  // Unused slot
        end
    end

    assign out_valid = s2_valid;

    always_comb begin
        out_res = s2_res;  // Tag and shift amount
        for (int i = 0; i < VEC_LEN_MAX; i++) begin
            out_res.vec[i] = shifted[i];
        end
    end

    // Dispatcher holds lane_valid low while reset is on
    rst_idle_a: assert property (@(posedge clk) rst |-> in_valid !== 1'b1)
        else $error("lane issued during reset");

endmodule

//--- src/expmul_pkg.sv
/* Opcode enum plus request and result structs
   passed between dispatcher, lanes and collector */
package expmul_pkg;

    import fixed_point_pkg::*;

    // Request kind
    typedef enum logic {
        OP_RESCALE = 1'b0,  // Scale vector by exp(a - b)
        OP_BYPASS  = 1'b1   // Vector goes through untouched
    } opcode_e;

    // Sequence number chosen by the requester
    typedef logic [7:0] tag_t;

    // One rescale request
    typedef struct packed {
        opcode_e opcode;
        score_t  a_val;  // Current score, Q4.4
        score_t  b_val;  // Running max, Q4.4
        tag_t    tag;
        vec_t    vec;    // Elements at or above VEC_LEN are zero
    } expmul_req_t;

    // One rescaled vector
    typedef struct packed {
        tag_t   tag;     // Copied from the request
        shamt_t shamt;   // Shift that was applied
        vec_t   vec;     // Q9.17, each element >>> shamt
    } expmul_res_t;

endpackage

//--- src/fixed_point_pkg.sv
/* Fixed-point formats for the rescale datapath
   Score, difference, element, vector and shift-amount types */
package fixed_point_pkg;

    // Score and running max, Q4.4
    localparam int SCORE_I = 4;
    localparam int SCORE_F = 4;
    typedef logic signed [SCORE_I+SCORE_F-1:0] score_t;

    // a - b needs one more integer bit, Q5.4
    typedef logic signed [SCORE_I+SCORE_F:0] diff_t;

    // Difference with two fraction bits dropped, Q5.2
    typedef logic signed [SCORE_I+2:0] diff_q2_t;

    // log2(e)*d approximation, Q6.2
    typedef logic signed [SCORE_I+3:0] log_t;

    // Vector element, Q9.17
    localparam int ELEM_I = 9;
    localparam int ELEM_F = 17;
    typedef logic signed [ELEM_I+ELEM_F-1:0] elem_t;

    // Widest vector a request can carry
    localparam int VEC_LEN_MAX = 8;
    typedef elem_t [VEC_LEN_MAX-1:0] vec_t;  // Element 0 in the low bits

    // Right-shift amount, 2^-15 is the smallest scale applied
    localparam int MAX_SHIFT = 15;
    typedef logic [3:0] shamt_t;

endpackage
